// File: rtl/rx_chain_defines.svh
// Settings register offsets and field positions for the receive chain, added to each BASE
`ifndef RX_CHAIN_DEFINES_SVH
`define RX_CHAIN_DEFINES_SVH

// number of samples in the burst, with the start-now flag in the top bit
`define SR_RX_NUM 0

// upper half of the 64-bit command time
`define SR_RX_TIME_HI 1

// lower half of the command time, a write here arms the command
`define SR_RX_TIME_LO 2

// samples per packet, zero behaves as one
`define SR_RX_SPP 4

// stream id carried in the low half of every header word
`define SR_RX_SID 5

// bit 0 turns on the 16-to-8 packing stage
`define SR_DSP_CTRL 9

// field positions inside the SR_RX_NUM word
`define SR_NUM_NOW_BIT 31
`define RX_NUM_WIDTH 28

// width of the packet counter in the header word
`define PKT_COUNT_WIDTH 4

`endif

// File: rtl/rx_chain_pkg.sv
// Shared types of the receive chain, referenced by scoped name from every RTL module
`default_nettype none

package rx_chain_pkg;

   // one complex sample, I in the upper half and Q in the lower half
   typedef logic [31:0] sample_t;

   // free running time counter value
   typedef logic [63:0] vita_time_t;

   // settings bus address and data
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // one 36-bit stream word as it travels between the framer, packer and outside
   typedef struct packed {
      logic [1:0]  occ;
      logic        eop;
      logic        sop;
      logic [31:0] data;
   } rx_word_t;

   // time-tagged sample handed from the control block to the framer
   // error entries carry no valid sample, only the time of the overrun
   typedef struct packed {
      sample_t    sample;
      vita_time_t tstamp;
      logic       first;
      logic       last;
      logic       error;
   } sample_entry_t;

   // run control of a single burst
   typedef enum logic [1:0] {
      ctrl_idle,
      ctrl_wait_time,
      ctrl_running,
      ctrl_report_overrun
   } ctrl_state_e;

   // position of the framer inside the packet it is building
   typedef enum logic [1:0] {
      fr_header,
      fr_time_hi,
      fr_time_lo,
      fr_payload
   } framer_state_e;

endpackage

`default_nettype wire

// File: rtl/vita_rx_control.sv
// Burst command registers and run control that turn strobed samples into time-tagged entries
`default_nettype none
`include "rx_chain_defines.svh"

module vita_rx_control #(
   parameter int BASE = 0
) (
   input  wire                              clk,
   input  wire                              rst_i,
   input  wire                              set_stb_i,
   input  wire rx_chain_pkg::set_addr_t     set_addr_i,
   input  wire rx_chain_pkg::set_data_t     set_data_i,
   input  wire rx_chain_pkg::vita_time_t    vita_time_i,
   input  wire rx_chain_pkg::sample_t       sample_i,
   input  wire                              strobe_i,
   output logic                             run_o,
   output logic                             overrun_o,
   output rx_chain_pkg::sample_entry_t      entry_o,
   output logic                             entry_src_rdy_o,
   input  wire                              entry_dst_rdy_i
);

   localparam rx_chain_pkg::set_addr_t ADDR_NUM     = rx_chain_pkg::set_addr_t'(BASE + `SR_RX_NUM);
   localparam rx_chain_pkg::set_addr_t ADDR_TIME_HI =
      rx_chain_pkg::set_addr_t'(BASE + `SR_RX_TIME_HI);
   localparam rx_chain_pkg::set_addr_t ADDR_TIME_LO =
      rx_chain_pkg::set_addr_t'(BASE + `SR_RX_TIME_LO);

   rx_chain_pkg::ctrl_state_e state;
   rx_chain_pkg::set_data_t   time_hi_q;
   rx_chain_pkg::vita_time_t  cmd_time;
   rx_chain_pkg::vita_time_t  ovf_time;
   logic [`RX_NUM_WIDTH-1:0]  num_q;
   logic [`RX_NUM_WIDTH-1:0]  num_left;
   logic                      now_q;
   logic                      first_pend;
   logic                      arm;
   logic                      hold_free;
   logic                      counted;
   logic                      collision;
   logic                      capture;
   logic                      post_error;
   logic                      final_smp;

   assign arm        = set_stb_i && (set_addr_i == ADDR_TIME_LO);
   // the holding register counts as free when the framer takes it on this same edge
   assign hold_free  = !entry_src_rdy_o || entry_dst_rdy_i;
   assign counted    = (state == rx_chain_pkg::ctrl_running) && strobe_i;
   assign collision  = counted && !hold_free;
   assign capture    = counted && hold_free;
   assign post_error = (state == rx_chain_pkg::ctrl_report_overrun) && hold_free;
   // a programmed count of zero behaves as a single sample
   assign final_smp  = (num_left <= `RX_NUM_WIDTH'd1);
   assign run_o      = (state == rx_chain_pkg::ctrl_running);

   always_ff @(posedge clk) begin
      if (rst_i) begin
         num_q     <= '0;
         now_q     <= 1'b0;
         time_hi_q <= '0;
      end else if (set_stb_i) begin
         if (set_addr_i == ADDR_NUM) begin
            num_q <= set_data_i[`RX_NUM_WIDTH-1:0];
            now_q <= set_data_i[`SR_NUM_NOW_BIT];
         end
         if (set_addr_i == ADDR_TIME_HI)
            time_hi_q <= set_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state           <= rx_chain_pkg::ctrl_idle;
         overrun_o       <= 1'b0;
         entry_src_rdy_o <= 1'b0;
         num_left        <= '0;
         first_pend      <= 1'b0;
      end else begin
         overrun_o <= collision;

         if (capture || post_error)
            entry_src_rdy_o <= 1'b1;
         else if (entry_dst_rdy_i)
            entry_src_rdy_o <= 1'b0;

         case (state)
            rx_chain_pkg::ctrl_idle: begin
               // commands written while a burst is in progress are ignored
               if (arm) begin
                  state      <= rx_chain_pkg::ctrl_wait_time;
                  num_left   <= num_q;
                  first_pend <= 1'b1;
               end
            end
            rx_chain_pkg::ctrl_wait_time: begin
               if (now_q || (vita_time_i >= cmd_time))
                  state <= rx_chain_pkg::ctrl_running;
            end
            rx_chain_pkg::ctrl_running: begin
               if (collision) begin
                  state <= rx_chain_pkg::ctrl_report_overrun;
               end else if (capture) begin
                  num_left   <= num_left - `RX_NUM_WIDTH'd1;
                  first_pend <= 1'b0;
                  if (final_smp)
                     state <= rx_chain_pkg::ctrl_idle;
               end
            end
            default: begin
               if (hold_free)
                  state <= rx_chain_pkg::ctrl_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (arm && (state == rx_chain_pkg::ctrl_idle))
         cmd_time <= {time_hi_q, set_data_i};
      if (collision)
         ovf_time <= vita_time_i;

      if (capture) begin
         entry_o.sample <= sample_i;
         entry_o.tstamp <= vita_time_i;
         entry_o.first  <= first_pend;
         entry_o.last   <= final_smp;
         entry_o.error  <= 1'b0;
      end else if (post_error) begin
         entry_o.sample <= '0;
         entry_o.tstamp <= ovf_time;
         entry_o.first  <= 1'b0;
         entry_o.last   <= 1'b0;
         entry_o.error  <= 1'b1;
      end else if (collision) begin
         // the stalled sample is now the final one of the aborted burst, so it closes its packet
         entry_o.last <= 1'b1;
      end
   end

   overrun_single_pulse: assert property (@(posedge clk) disable iff (rst_i)
      overrun_o |=> !overrun_o);

   // only the last flag may change on a stalled entry, at the overrun edge
   entry_stable_stalled: assert property (@(posedge clk) disable iff (rst_i)
      entry_src_rdy_o && !entry_dst_rdy_i |=> entry_src_rdy_o &&
      $stable({entry_o.sample, entry_o.tstamp, entry_o.first, entry_o.error}));

endmodule

`default_nettype wire

// File: rtl/vita_rx_framer.sv
// Packet framer that wraps time-tagged sample entries into header, time and payload words
`default_nettype none
`include "rx_chain_defines.svh"

module vita_rx_framer #(
   parameter int BASE = 0
) (
   input  wire                               clk,
   input  wire                               rst_i,
   input  wire                               set_stb_i,
   input  wire rx_chain_pkg::set_addr_t      set_addr_i,
   input  wire rx_chain_pkg::set_data_t      set_data_i,
   input  wire rx_chain_pkg::sample_entry_t  entry_i,
   input  wire                               entry_src_rdy_i,
   output logic                              entry_dst_rdy_o,
   output rx_chain_pkg::rx_word_t            data_o,
   output logic                              src_rdy_o,
   input  wire                               dst_rdy_i
);

   localparam rx_chain_pkg::set_addr_t ADDR_SPP = rx_chain_pkg::set_addr_t'(BASE + `SR_RX_SPP);
   localparam rx_chain_pkg::set_addr_t ADDR_SID = rx_chain_pkg::set_addr_t'(BASE + `SR_RX_SID);

   rx_chain_pkg::framer_state_e state;
   rx_chain_pkg::sample_entry_t hold;
   rx_chain_pkg::sample_entry_t pay_entry;
   rx_chain_pkg::rx_word_t      next_word;
   logic [15:0]                 spp_q;
   logic [15:0]                 spp_eff;
   logic [15:0]                 sid_q;
   logic [15:0]                 smp_cnt;
   logic [`PKT_COUNT_WIDTH-1:0] pkt_count;
   logic                        use_hold;
   logic                        out_free;
   logic                        pay_valid;
   logic                        pay_eop;
   logic                        load_word;

   assign out_free  = !src_rdy_o || dst_rdy_i;
   assign spp_eff   = (spp_q == 16'd0) ? 16'd1 : spp_q;
   // the opening entry is the first payload sample, later ones come straight from the input
   assign pay_entry = use_hold ? hold : entry_i;
   assign pay_valid = use_hold || entry_src_rdy_i;
   assign pay_eop   = pay_entry.last || (smp_cnt >= spp_eff - 16'd1);

   assign entry_dst_rdy_o = out_free && ((state == rx_chain_pkg::fr_header) ||
                            ((state == rx_chain_pkg::fr_payload) && !use_hold));

   always_comb begin
      next_word = '0;
      load_word = 1'b0;
      case (state)
         rx_chain_pkg::fr_header: begin
            next_word.sop  = 1'b1;
            next_word.data = {pkt_count, entry_i.first, entry_i.error, 10'd0, sid_q};
            load_word      = entry_src_rdy_i && out_free;
         end
         rx_chain_pkg::fr_time_hi: begin
            next_word.data = hold.tstamp[63:32];
            load_word      = out_free;
         end
         rx_chain_pkg::fr_time_lo: begin
            next_word.data = hold.tstamp[31:0];
            next_word.eop  = hold.error;
            load_word      = out_free;
         end
         default: begin
            next_word.data = pay_entry.sample;
            next_word.eop  = pay_eop;
            load_word      = pay_valid && out_free;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         spp_q <= '0;
         sid_q <= '0;
      end else if (set_stb_i) begin
         if (set_addr_i == ADDR_SPP)
            spp_q <= set_data_i[15:0];
         if (set_addr_i == ADDR_SID)
            sid_q <= set_data_i[15:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state     <= rx_chain_pkg::fr_header;
         src_rdy_o <= 1'b0;
         use_hold  <= 1'b0;
         smp_cnt   <= '0;
         pkt_count <= '0;
      end else begin
         if (load_word)
            src_rdy_o <= 1'b1;
         else if (dst_rdy_i)
            src_rdy_o <= 1'b0;

         if (load_word && next_word.eop)
            pkt_count <= pkt_count + `PKT_COUNT_WIDTH'd1;

         if (load_word) begin
            case (state)
               rx_chain_pkg::fr_header: begin
                  state    <= rx_chain_pkg::fr_time_hi;
                  use_hold <= 1'b1;
               end
               rx_chain_pkg::fr_time_hi: state <= rx_chain_pkg::fr_time_lo;
               rx_chain_pkg::fr_time_lo: begin
                  smp_cnt <= '0;
                  state   <= hold.error ? rx_chain_pkg::fr_header : rx_chain_pkg::fr_payload;
               end
               default: begin
                  smp_cnt  <= smp_cnt + 16'd1;
                  use_hold <= 1'b0;
                  if (pay_eop)
                     state <= rx_chain_pkg::fr_header;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_word && (state == rx_chain_pkg::fr_header))
         hold <= entry_i;
      if (load_word)
         data_o <= next_word;
   end

   // only an error packet may end right after its header words
   hdr_not_closed: assert property (@(posedge clk) disable iff (rst_i)
      src_rdy_o && use_hold && !hold.error |-> !data_o.eop);

endmodule

`default_nettype wire

// File: rtl/rx_pack_16to8.sv
// Stream stage that can narrow payload samples to 8-bit I/Q and pack two per word
`default_nettype none
`include "rx_chain_defines.svh"

module rx_pack_16to8 #(
   parameter int BASE = 0
) (
   input  wire                           clk,
   input  wire                           rst_i,
   input  wire                           set_stb_i,
   input  wire rx_chain_pkg::set_addr_t  set_addr_i,
   input  wire rx_chain_pkg::set_data_t  set_data_i,
   input  wire rx_chain_pkg::rx_word_t   data_i,
   input  wire                           src_rdy_i,
   output logic                          dst_rdy_o,
   output rx_chain_pkg::rx_word_t        data_o,
   output logic                          src_rdy_o,
   input  wire                           dst_rdy_i
);

   localparam rx_chain_pkg::set_addr_t ADDR_CTRL = rx_chain_pkg::set_addr_t'(BASE + `SR_DSP_CTRL);

   rx_chain_pkg::rx_word_t out_word;
   logic                   pack_en;
   logic [1:0]             word_idx;
   logic [15:0]            half_q;
   logic                   half_valid;
   logic [15:0]            narrowed;
   logic                   accept;
   logic                   is_hdr;
   logic                   packing;
   logic                   load_out;

   assign dst_rdy_o = !src_rdy_o || dst_rdy_i;
   assign accept    = src_rdy_i && dst_rdy_o;
   // word_idx saturates at 3 once the three header words of a packet have gone by
   assign is_hdr    = data_i.sop || (word_idx != 2'd3);
   assign packing   = pack_en && !is_hdr;
   // upper byte of I then upper byte of Q
   assign narrowed  = {data_i.data[31:24], data_i.data[15:8]};
   assign load_out  = accept && (!packing || half_valid || data_i.eop);

   always_comb begin
      out_word = data_i;
      if (packing)
         out_word.data = half_valid ? {half_q, narrowed} : {narrowed, 16'h0000};
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pack_en    <= 1'b0;
         word_idx   <= 2'd3;
         half_valid <= 1'b0;
         src_rdy_o  <= 1'b0;
      end else begin
         if (set_stb_i && (set_addr_i == ADDR_CTRL))
            pack_en <= set_data_i[0];
         if (load_out)
            src_rdy_o <= 1'b1;
         else if (dst_rdy_i)
            src_rdy_o <= 1'b0;
         if (accept) begin
            if (data_i.sop)
               word_idx <= 2'd1;
            else if (word_idx != 2'd3)
               word_idx <= word_idx + 2'd1;
            half_valid <= packing && !half_valid && !data_i.eop;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && packing && !half_valid)
         half_q <= narrowed;
      if (load_out)
         data_o <= out_word;
   end

   out_stable_stalled: assert property (@(posedge clk) disable iff (rst_i)
      src_rdy_o && !dst_rdy_i |=> src_rdy_o && $stable(data_o));

endmodule

`default_nettype wire

// File: rtl/vita_rx_chain.sv
// Receive chain top level, control feeding the framer and then the optional 16-to-8 packer
`default_nettype none

module vita_rx_chain #(
   parameter int BASE = 0
) (
   input  wire                            clk,
   input  wire                            rst_i,
   input  wire                            set_stb_i,
   input  wire rx_chain_pkg::set_addr_t   set_addr_i,
   input  wire rx_chain_pkg::set_data_t   set_data_i,
   input  wire rx_chain_pkg::vita_time_t  vita_time_i,
   input  wire rx_chain_pkg::sample_t     sample_i,
   input  wire                            strobe_i,
   output logic                           run_o,
   output logic                           overrun_o,
   output rx_chain_pkg::rx_word_t         rx_data_o,
   output logic                           rx_src_rdy_o,
   input  wire                            rx_dst_rdy_i
);

   rx_chain_pkg::sample_entry_t entry;
   logic                        entry_src_rdy;
   logic                        entry_dst_rdy;
   rx_chain_pkg::rx_word_t      framed_data;
   logic                        framed_src_rdy;
   logic                        framed_dst_rdy;

   vita_rx_control #(.BASE(BASE)) vita_rx_control_inst (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time_i), .sample_i(sample_i), .strobe_i(strobe_i),
      .run_o(run_o), .overrun_o(overrun_o),
      .entry_o(entry), .entry_src_rdy_o(entry_src_rdy), .entry_dst_rdy_i(entry_dst_rdy));

   vita_rx_framer #(.BASE(BASE)) vita_rx_framer_inst (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .entry_i(entry), .entry_src_rdy_i(entry_src_rdy), .entry_dst_rdy_o(entry_dst_rdy),
      .data_o(framed_data), .src_rdy_o(framed_src_rdy), .dst_rdy_i(framed_dst_rdy));

   rx_pack_16to8 #(.BASE(BASE)) rx_pack_16to8_inst (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .data_i(framed_data), .src_rdy_i(framed_src_rdy), .dst_rdy_o(framed_dst_rdy),
      .data_o(rx_data_o), .src_rdy_o(rx_src_rdy_o), .dst_rdy_i(rx_dst_rdy_i));

endmodule

`default_nettype wire

// File: testbench/tb_vita_rx_chain.sv
// Self-checking testbench for the receive chain, runs a scenario table and compares every output word
`default_nettype none
`include "rx_chain_defines.svh"

module tb_vita_rx_chain;

   // one scenario, bp is 0 for always ready, 1 for random, 2 for held low until an overrun
   typedef struct packed {
      logic       timed;
      logic [7:0] num;
      logic [7:0] spp;
      logic       pack;
      logic [3:0] spacing;
      logic [1:0] bp;
      logic       mid_rst;
   } row_t;

   logic                       clk;
   logic                       rst_i;
   logic                       set_stb_i;
   rx_chain_pkg::set_addr_t    set_addr_i;
   rx_chain_pkg::set_data_t    set_data_i;
   rx_chain_pkg::vita_time_t   vita_time_i;
   rx_chain_pkg::sample_t      sample_i;
   logic                       strobe_i;
   logic                       run_o;
   logic                       overrun_o;
   rx_chain_pkg::rx_word_t     rx_data_o;
   logic                       rx_src_rdy_o;
   logic                       rx_dst_rdy_i;

   row_t                       rows[7];
   string                      names[7];
   rx_chain_pkg::sample_t      rec_smp[$];
   rx_chain_pkg::vita_time_t   rec_time[$];
   rx_chain_pkg::rx_word_t     exp_q[$];
   rx_chain_pkg::rx_word_t     got_q[$];
   integer                     seed;
   logic                       strobe_on;
   int                         spacing;
   logic [1:0]                 bp_mode;
   int                         cyc;
   int                         overrun_cnt;
   logic [3:0]                 pkt_model;

   vita_rx_chain #(.BASE(0)) vita_rx_chain_inst (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .vita_time_i(vita_time_i), .sample_i(sample_i), .strobe_i(strobe_i),
      .run_o(run_o), .overrun_o(overrun_o),
      .rx_data_o(rx_data_o), .rx_src_rdy_o(rx_src_rdy_o), .rx_dst_rdy_i(rx_dst_rdy_i));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // every input changes on the falling edge, counted strobes and output words are logged here
   always @(negedge clk) begin
      vita_time_i = vita_time_i + 64'd1;
      sample_i    = $random(seed);
      strobe_i    = strobe_on && ((cyc % spacing) == 0);
      cyc         = cyc + 1;
      case (bp_mode)
         2'd0:    rx_dst_rdy_i = 1'b1;
         2'd1:    rx_dst_rdy_i = (($random(seed) & 7) != 0);
         default: rx_dst_rdy_i = 1'b0;
      endcase
      // run_o is stable here and holds through the coming rising edge
      if (run_o && strobe_i) begin
         rec_smp.push_back(sample_i);
         rec_time.push_back(vita_time_i);
      end
      if (rx_src_rdy_o && rx_dst_rdy_i)
         got_q.push_back(rx_data_o);
      if (overrun_o)
         overrun_cnt = overrun_cnt + 1;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input rx_chain_pkg::rx_word_t exp,
                             input rx_chain_pkg::rx_word_t act);
      if (act !== exp)
         report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic compare_time(input string name, input rx_chain_pkg::vita_time_t exp,
                               input rx_chain_pkg::vita_time_t act);
      if (act !== exp)
         report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
   endtask

   task automatic expect_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_failure($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
   endtask

   task automatic write_setting(input int offset, input rx_chain_pkg::set_data_t value);
      @(negedge clk);
      set_stb_i  = 1'b1;
      set_addr_i = offset[7:0];
      set_data_i = value;
      @(negedge clk);
      set_stb_i  = 1'b0;
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_i = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_i = 1'b0;
   endtask

   task automatic clear_history();
      rec_smp.delete();
      rec_time.delete();
      got_q.delete();
      overrun_cnt = 0;
   endtask

   // upper byte of I followed by upper byte of Q
   function automatic logic [15:0] narrow_sample(input rx_chain_pkg::sample_t s);
      return {s[31:24], s[15:8]};
   endfunction

   function automatic rx_chain_pkg::rx_word_t make_word(input logic sop, input logic eop,
                                                        input logic [31:0] data);
      rx_chain_pkg::rx_word_t w;
      w      = '0;
      w.sop  = sop;
      w.eop  = eop;
      w.data = data;
      return w;
   endfunction

   task automatic add_head_words(input logic first, input logic error, input logic [15:0] sid,
                                 input rx_chain_pkg::vita_time_t t);
      exp_q.push_back(make_word(1'b1, 1'b0, {pkt_model, first, error, 10'd0, sid}));
      exp_q.push_back(make_word(1'b0, 1'b0, t[63:32]));
      exp_q.push_back(make_word(1'b0, error, t[31:0]));
      pkt_model = pkt_model + 4'd1;
   endtask

   task automatic append_payload(input int start, input int cnt, input logic pack);
      int          k;
      logic [15:0] low;
      if (!pack) begin
         for (k = 0; k < cnt; k++)
            exp_q.push_back(make_word(1'b0, k == cnt - 1, rec_smp[start + k]));
      end else begin
         for (k = 0; k < cnt; k += 2) begin
            low = (k + 1 < cnt) ? narrow_sample(rec_smp[start + k + 1]) : 16'h0000;
            exp_q.push_back(make_word(1'b0, k + 2 >= cnt,
                                      {narrow_sample(rec_smp[start + k]), low}));
         end
      end
   endtask

   task automatic build_expected(input int spp, input logic pack, input logic [15:0] sid,
                                 input logic ovr);
      int                       n;
      int                       i;
      int                       len;
      int                       spp_eff;
      rx_chain_pkg::vita_time_t err_time;
      exp_q.delete();
      n        = rec_smp.size();
      err_time = '0;
      if (ovr) begin
         // the colliding strobe loses its sample, only its time goes into the error packet
         err_time = rec_time[n - 1];
         n        = n - 1;
      end
      spp_eff = (spp == 0) ? 1 : spp;
      i       = 0;
      while (i < n) begin
         len = (n - i < spp_eff) ? n - i : spp_eff;
         add_head_words(i == 0, 1'b0, sid, rec_time[i]);
         append_payload(i, len, pack);
         i = i + len;
      end
      if (ovr)
         add_head_words(1'b0, 1'b1, sid, err_time);
   endtask

   initial begin
      int                       r;
      int                       i;
      int                       guard;
      row_t                     row;
      string                    name;
      logic [15:0]              sid;
      rx_chain_pkg::vita_time_t cmd_time;

      rst_i        = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      vita_time_i  = 64'h0000_0000_ffff_ff00;
      sample_i     = '0;
      strobe_i     = 1'b0;
      rx_dst_rdy_i = 1'b1;
      seed         = 32'ha4ff1ff0;
      strobe_on    = 1'b0;
      spacing      = 1;
      bp_mode      = 2'd0;
      cyc          = 0;
      overrun_cnt  = 0;
      pkt_model    = 4'd0;

      // timed, num, spp, pack, spacing, bp, mid_rst
      rows[0] = {1'b0, 8'd10, 8'd4, 1'b0, 4'd3, 2'd0, 1'b0};
      rows[1] = {1'b1, 8'd2,  8'd4, 1'b0, 4'd1, 2'd0, 1'b0};
      rows[2] = {1'b0, 8'd12, 8'd5, 1'b0, 4'd6, 2'd1, 1'b0};
      rows[3] = {1'b0, 8'd7,  8'd7, 1'b1, 4'd3, 2'd0, 1'b0};
      rows[4] = {1'b0, 8'd10, 8'd4, 1'b0, 4'd1, 2'd2, 1'b0};
      rows[5] = {1'b0, 8'd20, 8'd4, 1'b0, 4'd3, 2'd0, 1'b1};
      rows[6] = {1'b0, 8'd4,  8'd4, 1'b0, 4'd3, 2'd0, 1'b0};
      names[0] = "immediate burst";
      names[1] = "timed start";
      names[2] = "random back-pressure";
      names[3] = "pack 7 samples";
      names[4] = "overrun";
      names[5] = "reset mid run";
      names[6] = "burst after reset";

      apply_reset();

      for (r = 0; r < 7; r++) begin
         row  = rows[r];
         name = names[r];
         sid  = 16'h0a00 + r[15:0];
         @(posedge clk);
         clear_history();
         cmd_time = vita_time_i + 64'd40;
         write_setting(`SR_RX_NUM, {!row.timed, 3'b000, 20'd0, row.num});
         write_setting(`SR_RX_SPP, {24'd0, row.spp});
         write_setting(`SR_RX_SID, {16'd0, sid});
         write_setting(`SR_DSP_CTRL, {31'd0, row.pack});
         write_setting(`SR_RX_TIME_HI, cmd_time[63:32]);
         write_setting(`SR_RX_TIME_LO, cmd_time[31:0]);
         @(posedge clk);
         spacing   = row.spacing;
         bp_mode   = row.bp;
         strobe_on = 1'b1;

         guard = 0;
         while ((rec_smp.size() < row.num) && (overrun_cnt == 0) &&
                !(row.mid_rst && (rec_smp.size() >= 5))) begin
            @(posedge clk);
            guard = guard + 1;
            if (guard > 2000)
               report_failure($sformatf("timeout waiting for the samples of %s", name));
         end
         strobe_on = 1'b0;

         if (row.mid_rst) begin
            apply_reset();
            expect_flag($sformatf("%s run_o", name), 1'b0, run_o);
            expect_flag($sformatf("%s overrun_o", name), 1'b0, overrun_o);
            expect_flag($sformatf("%s rx_src_rdy_o", name), 1'b0, rx_src_rdy_o);
            @(posedge clk);
            clear_history();
            pkt_model = 4'd0;
            continue;
         end

         // release the output once the overrun has been seen
         if (row.bp == 2'd2)
            bp_mode = 2'd0;
         @(negedge clk);
         expect_flag($sformatf("%s run_o after burst", name), 1'b0, run_o);
         @(posedge clk);
         build_expected(row.spp, row.pack, sid, row.bp == 2'd2);

         guard = 0;
         while (got_q.size() < exp_q.size()) begin
            @(posedge clk);
            guard = guard + 1;
            if (guard > 2000)
               report_failure($sformatf("timeout waiting for the output words of %s", name));
         end
         if (row.timed) begin
            compare_time($sformatf("%s first count", name), cmd_time + 64'd1, rec_time[0]);
            compare_time($sformatf("%s packet time", name), cmd_time + 64'd1,
                         {got_q[1].data, got_q[2].data});
         end
         expect_flag($sformatf("%s word count", name), 1'b1, got_q.size() == exp_q.size());
         for (i = 0; i < exp_q.size(); i++)
            check_word($sformatf("%s word %0d", name, i), exp_q[i], got_q[i]);
         expect_flag($sformatf("%s overrun pulse", name), row.bp == 2'd2, overrun_cnt == 1);
         expect_flag($sformatf("%s overrun limit", name), 1'b1, overrun_cnt <= 1);
         @(negedge clk);
         expect_flag($sformatf("%s output idle", name), 1'b0, rx_src_rdy_o);
      end

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/rx_chain_pkg.sv
rtl/vita_rx_control.sv
rtl/vita_rx_framer.sv
rtl/rx_pack_16to8.sv
rtl/vita_rx_chain.sv
testbench/tb_vita_rx_chain.sv
